/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fft_butterfly_tb
FILELIST  ?= fft_butterfly.f
SIM_ARGS  ?= +verilator+error+limit+1000
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Verification failed
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "no result line in $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/fft_butterfly_chk.sv */
`timescale 1ns/10ps

module fft_butterfly_chk
  import fft_fmt_pkg::*;
(
  input logic    clk,
  input logic    reset,
  input logic    in_valid,
  input logic    out_valid,
  input result_t x_re,
  input result_t x_im,
  input result_t y_re,
  input result_t y_im
);

  // cycles since reset released, saturates at pipeline depth
  logic [1:0] since_reset;
  // read by the testbench at the end of the run
  int fail_count = 0;

  always_ff @(posedge clk) begin
    if (reset) begin
      since_reset <= 2'd0;
    end else if (since_reset != 2'd2) begin
      since_reset <= since_reset + 2'd1;
    end
  end

  // reset clears out_valid by the next edge
  a_reset_clears: assert property (@(posedge clk) reset |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset");
      fail_count++;
    end

  // fixed two-cycle latency, both stages clear of reset
  a_latency: assert property (@(posedge clk)
      (since_reset == 2'd2) |-> (out_valid == $past(in_valid, 2)))
    else begin
      $error("out_valid does not follow in_valid by two cycles");
      fail_count++;
    end

  a_known: assert property (@(posedge clk)
      out_valid |-> !$isunknown({x_re, x_im, y_re, y_im}))
    else begin
      $error("unknown butterfly output while out_valid is high");
      fail_count++;
    end

endmodule

bind fft_butterfly_top fft_butterfly_chk i_fft_butterfly_chk (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .x_re      (x_re),
  .x_im      (x_im),
  .y_re      (y_re),
  .y_im      (y_im)
);

/* bench/fft_butterfly_tb.sv */
`timescale 1ns/10ps

module fft_butterfly_tb
  import fft_fmt_pkg::*;
  import fft_op_pkg::*;
();

  // run length in clock cycles
  localparam int reset_cycles = 5;
  localparam int stim_cycles = 1200;
  localparam int max_cycles = reset_cycles + stim_cycles + 20;
  // strobe to out_valid
  localparam int latency = 2;

  // one predicted butterfly result
  typedef struct {
    string  name;
    int     due;
    longint xr;
    longint xi;
    longint yr;
    longint yi;
  } expect_t;

  logic           clk;
  logic           reset;
  logic           in_valid;
  bfly_op_e       op;
  logic           scale;
  logic [k_w-1:0] k;
  sample_t        a_re;
  sample_t        a_im;
  sample_t        b_re;
  sample_t        b_im;
  logic           out_valid;
  result_t        x_re;
  result_t        x_im;
  result_t        y_re;
  result_t        y_im;

  // model twiddle table rounded from sin(2*pi*i/N) * 2^16
  longint  sin_tbl [fft_n];
  expect_t exp_q [$];
  int      cyc = 0;
  int      errors = 0;
  int      checks = 0;

  // 4 ns period
  always #2 clk = ~clk;

  fft_butterfly_top i_fft_butterfly_top (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .op        (op),
    .scale     (scale),
    .k         (k),
    .a_re      (a_re),
    .a_im      (a_im),
    .b_re      (b_re),
    .b_im      (b_im),
    .out_valid (out_valid),
    .x_re      (x_re),
    .x_im      (x_im),
    .y_re      (y_re),
    .y_im      (y_im)
  );

  // division rounding toward -inf for positive d
  function automatic longint floor_div(input longint n, input longint d);
    if (n >= 0) begin
      return n / d;
    end
    return -((-n + d - 1) / d);
  endfunction

  // nearest integer with halves away from zero
  function automatic longint round_real(input real v);
    if (v >= 0.0) begin
      return longint'($floor(v + 0.5));
    end
    return -longint'($floor(-v + 0.5));
  endfunction

  function automatic void build_table();
    real pi_val;
    pi_val = 3.14159265358979323846;
    for (int i = 0; i < fft_n; i++) begin
      sin_tbl[i] = round_real($sin(2.0 * pi_val * i / fft_n) * 65536.0);
    end
  endfunction

  // random sample with the extremes mixed in now and then
  function automatic sample_t rand_sample();
    int unsigned pick;
    pick = $urandom_range(0, 15);
    if (pick == 0) begin
      return sample_t'(-32768);
    end
    if (pick == 1) begin
      return sample_t'(32767);
    end
    return sample_t'($urandom);
  endfunction

  // odd negative sample from -1 down to -32767
  function automatic sample_t odd_negative();
    int v;
    v = -(2 * int'($urandom_range(0, 16383)) + 1);
    return sample_t'(v);
  endfunction

  // predicted outputs for one strobe
  task automatic push_expect(input string name, input bfly_op_e op_v, input logic scale_v,
                             input logic [k_w-1:0] k_v, input sample_t ar, input sample_t ai,
                             input sample_t br, input sample_t bi);
    expect_t e;
    longint  a_r;
    longint  a_i;
    longint  b_r;
    longint  b_i;
    longint  w_r;
    longint  w_i;
    longint  t_r;
    longint  t_i;
    longint  d;
    // block scaling floors each sample by half
    d = scale_v ? 2 : 1;
    a_r = floor_div(longint'(ar), d);
    a_i = floor_div(longint'(ai), d);
    b_r = floor_div(longint'(br), d);
    b_i = floor_div(longint'(bi), d);
    // cosine a quarter turn on from the sine
    w_r = sin_tbl[(int'(k_v) + fft_n / 4) % fft_n];
    w_i = (op_v == op_inv) ? sin_tbl[k_v] : -sin_tbl[k_v];
    t_r = floor_div(b_r * w_r - b_i * w_i, longint'(1) << tw_frac);
    t_i = floor_div(b_r * w_i + b_i * w_r, longint'(1) << tw_frac);
    e.name = name;
    e.due = cyc + latency;
    e.xr = a_r + t_r;
    e.xi = a_i + t_i;
    e.yr = a_r - t_r;
    e.yi = a_i - t_i;
    exp_q.push_back(e);
  endtask

  // one strobe on the next falling edge
  task automatic send(input string name, input bfly_op_e op_v, input logic scale_v,
                      input logic [k_w-1:0] k_v, input sample_t ar, input sample_t ai,
                      input sample_t br, input sample_t bi);
    @(negedge clk);
    in_valid = 1'b1;
    op = op_v;
    scale = scale_v;
    k = k_v;
    a_re = ar;
    a_im = ai;
    b_re = br;
    b_im = bi;
    push_expect(name, op_v, scale_v, k_v, ar, ai, br, bi);
  endtask

  task automatic send_random(input string name);
    bfly_op_e       op_v;
    logic           s_v;
    logic [k_w-1:0] k_v;
    op_v = bfly_op_e'($urandom_range(0, 1));
    s_v = ($urandom_range(0, 1) == 1);
    k_v = k_w'($urandom_range(0, fft_n - 1));
    send(name, op_v, s_v, k_v, rand_sample(), rand_sample(), rand_sample(), rand_sample());
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  // reset in mid-stream with the strobe dropped
  task automatic apply_reset(input int n);
    @(negedge clk);
    in_valid = 1'b0;
    reset = 1'b1;
    repeat (n) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic check_value(input string name, input string field, input longint exp_v,
                             input longint act_v);
    checks++;
    if (exp_v != act_v) begin
      errors++;
      $display("FAILED %s %s: expected %0d, actual %0d", name, field, exp_v, act_v);
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin : monitor
    expect_t e;
    if (reset) begin
      // in-flight results are lost on reset
      exp_q.delete();
    end else if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
      e = exp_q.pop_front();
      if (out_valid !== 1'b1) begin
        errors++;
        $display("missing out_valid for test %s at cycle %0d", e.name, cyc);
      end else begin
        check_value(e.name, "x_re", e.xr, longint'(x_re));
        check_value(e.name, "x_im", e.xi, longint'(x_im));
        check_value(e.name, "y_re", e.yr, longint'(y_re));
        check_value(e.name, "y_im", e.yi, longint'(y_im));
      end
    end else if (out_valid !== 1'b0) begin
      errors++;
      $display("out_valid at cycle %0d without a strobe two cycles before", cyc);
    end
  end

  // cycle count and run limit
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= max_cycles) begin
      $display("timeout after %0d cycles, stimulus or output drain did not finish", cyc);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin : stimulus
    sample_t        ar;
    sample_t        ai;
    sample_t        br;
    sample_t        bi;
    logic [k_w-1:0] kk;
    int             asrt;
    clk = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    op = op_fwd;
    scale = 1'b0;
    k = '0;
    a_re = '0;
    a_im = '0;
    b_re = '0;
    b_im = '0;
    void'($urandom(32'h786b5915));
    build_table();
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    idle(1);

    // W = 1 gives the plain sum and difference
    repeat (20) begin
      send("unit_twiddle", op_fwd, 1'b0, k_w'(0),
           rand_sample(), rand_sample(), rand_sample(), rand_sample());
    end
    // W is -j forward and +j inverse
    repeat (10) begin
      send("quarter_fwd", op_fwd, 1'b0, k_w'(fft_n / 4),
           rand_sample(), rand_sample(), rand_sample(), rand_sample());
    end
    repeat (10) begin
      send("quarter_inv", op_inv, 1'b0, k_w'(fft_n / 4),
           rand_sample(), rand_sample(), rand_sample(), rand_sample());
    end
    idle(2);

    // same operands in both directions
    repeat (20) begin
      ar = rand_sample();
      ai = rand_sample();
      br = rand_sample();
      bi = rand_sample();
      kk = k_w'($urandom_range(0, fft_n - 1));
      send("conj_fwd", op_fwd, 1'b0, kk, ar, ai, br, bi);
      send("conj_inv", op_inv, 1'b0, kk, ar, ai, br, bi);
    end
    idle(2);

    // halving where odd negatives floor downward
    repeat (40) begin
      kk = k_w'($urandom_range(0, fft_n - 1));
      send("scaling", bfly_op_e'($urandom_range(0, 1)), 1'b1, kk,
           odd_negative(), rand_sample(), odd_negative(), rand_sample());
    end
    idle(2);

    // streaming with gaps and then a reset with results in flight
    repeat (30) begin
      send_random("stream");
      if ($urandom_range(0, 3) == 0) begin
        idle(int'($urandom_range(1, 2)));
      end
    end
    repeat (6) send_random("stream_pre_reset");
    apply_reset(3);
    // out_valid must stay low here
    idle(3);
    repeat (20) send_random("stream_post_reset");
    idle(2);

    // bulk random with rare single gaps
    repeat (800) begin
      send_random("random");
      if ($urandom_range(0, 9) == 0) begin
        idle(1);
      end
    end
    idle(latency + 2);
    while (exp_q.size() != 0) @(negedge clk);

    asrt = i_fft_butterfly_top.i_fft_butterfly_chk.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt);
    if (errors == 0 && asrt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* design/butterfly_core.sv */
`timescale 1ns/10ps

module butterfly_core
  import fft_fmt_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  sample_if.dst    smp,
  input  twiddle_t w_re,
  input  twiddle_t w_im,
  output logic     out_valid,
  output result_t  x_re,
  output result_t  x_im,
  output result_t  y_re,
  output result_t  y_im
);

  // partial products, full width of sample times twiddle
  logic signed [data_w+tw_w-1:0] p_rr;
  logic signed [data_w+tw_w-1:0] p_ii;
  logic signed [data_w+tw_w-1:0] p_ri;
  logic signed [data_w+tw_w-1:0] p_ir;

  // one extra bit for the sum or difference of two products
  logic signed [data_w+tw_w:0] t_re_full;
  logic signed [data_w+tw_w:0] t_im_full;

  // t = b * W after the floor shift
  result_t t_re;
  result_t t_im;

  // a sign-extended to the result width
  result_t a_re_x;
  result_t a_im_x;

  always_comb begin
    // b_re*w_re, b_im*w_im, b_re*w_im, b_im*w_re
    p_rr = (data_w + tw_w)'(smp.b_re) * (data_w + tw_w)'(w_re);
    p_ii = (data_w + tw_w)'(smp.b_im) * (data_w + tw_w)'(w_im);
    p_ri = (data_w + tw_w)'(smp.b_re) * (data_w + tw_w)'(w_im);
    p_ir = (data_w + tw_w)'(smp.b_im) * (data_w + tw_w)'(w_re);

    // complex multiply
    t_re_full = (data_w + tw_w + 1)'(p_rr) - (data_w + tw_w + 1)'(p_ii);
    t_im_full = (data_w + tw_w + 1)'(p_ri) + (data_w + tw_w + 1)'(p_ir);

    // drop the twiddle fraction, floor via arithmetic shift
    // |t| stays below 2**16 so the upper bits are pure sign
    t_re = result_t'(t_re_full >>> tw_frac);
    t_im = result_t'(t_im_full >>> tw_frac);

    a_re_x = result_t'(smp.a_re);
    a_im_x = result_t'(smp.a_im);
  end

  // output valid follows the sample strobe by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= smp.valid;
    end
  end

  // sum and difference, captured only for a valid pair
  // 18 bits hold a + t and a - t without wrap
  always_ff @(posedge clk) begin
    if (smp.valid) begin
      x_re <= a_re_x + t_re;
      x_im <= a_im_x + t_im;
      y_re <= a_re_x - t_re;
      y_im <= a_im_x - t_im;
    end
  end

endmodule

/* design/fft_butterfly_top.sv */
`timescale 1ns/10ps

module fft_butterfly_top
  import fft_fmt_pkg::*;
  import fft_op_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           in_valid,
  input  bfly_op_e       op,
  input  logic           scale,
  input  logic [k_w-1:0] k,
  input  sample_t        a_re,
  input  sample_t        a_im,
  input  sample_t        b_re,
  input  sample_t        b_im,
  output logic           out_valid,
  output result_t        x_re,
  output result_t        x_im,
  output result_t        y_re,
  output result_t        y_im
);

  // registered operand pair, stage 1 to stage 2
  sample_if smp ();

  // twiddle, aligned with smp.valid
  twiddle_t w_re;
  twiddle_t w_im;

  // stage 1, sample capture and scaling
  sample_stage i_sample_stage (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .scale    (scale),
    .a_re     (a_re),
    .a_im     (a_im),
    .b_re     (b_re),
    .b_im     (b_im),
    .smp      (smp.src)
  );

  // stage 1 in parallel, twiddle from the sine table
  twiddle_lookup i_twiddle_lookup (
    .clk  (clk),
    .k    (k),
    .op   (op),
    .w_re (w_re),
    .w_im (w_im)
  );

  // stage 2, multiply and sum/difference
  butterfly_core i_butterfly_core (
    .clk       (clk),
    .reset     (reset),
    .smp       (smp.dst),
    .w_re      (w_re),
    .w_im      (w_im),
    .out_valid (out_valid),
    .x_re      (x_re),
    .x_im      (x_im),
    .y_re      (y_re),
    .y_im      (y_im)
  );

endmodule

/* design/fft_fmt_pkg.sv */
package fft_fmt_pkg;

  // transform size and twiddle index width
  localparam int fft_n = 32;
  localparam int k_w = 5;

  // input samples, signed integer
  localparam int data_w = 16;

  // twiddle format
  // 18 bits signed so that +1.0 (65536) is representable
  localparam int tw_w = 18;
  localparam int tw_frac = 16;

  // butterfly outputs
  // two bits of growth over the input samples
  localparam int out_w = 18;

  // signed input sample
  typedef logic signed [data_w-1:0] sample_t;

  // signed twiddle component, tw_frac fractional bits
  typedef logic signed [tw_w-1:0] twiddle_t;

  // signed butterfly result
  typedef logic signed [out_w-1:0] result_t;

endpackage

/* design/fft_op_pkg.sv */
package fft_op_pkg;

  // butterfly direction
  // op_fwd uses W = cos - j*sin
  // op_inv uses the conjugate, W = cos + j*sin
  typedef enum logic {
    op_fwd = 1'b0,
    op_inv = 1'b1
  } bfly_op_e;

endpackage

/* design/fft_sine_wave.sv */
`timescale 1ns/10ps

// sine table over one full turn, N points
// entries carry D fractional bits, sign-extended to tw_w bits
module fft_sine_wave
  import fft_fmt_pkg::*;
#(
  parameter int N = fft_n,
  parameter int D = tw_frac
) (
  output twiddle_t out [N]
);

  // pi from the arccosine, evaluated at elaboration
  localparam real pi = $acos(-1.0);

  genvar i;

  generate
    for (i = 0; i < N; i++) begin : g_entry
      // real-valued sine for this index
      localparam real sin_val = $sin(2.0 * pi * i / N);
      // int' rounds to nearest
      localparam logic signed [31:0] fixed_val = int'(sin_val * (2.0 ** D));

      // keep D+1 low bits, extend the sign up to tw_w
      // sin(pi/2) lands at exactly 2**D
      assign out[i] = {{(tw_w - D - 1){fixed_val[31]}}, fixed_val[D:0]};
    end
  endgenerate

endmodule

/* design/sample_if.sv */
`timescale 1ns/10ps

// registered operand pair from the sample stage to the core
interface sample_if
  import fft_fmt_pkg::*;
();

  // high for one cycle per operand pair
  logic    valid;

  // first operand a, second operand b
  sample_t a_re;
  sample_t a_im;
  sample_t b_re;
  sample_t b_im;

  // producer side
  modport src (output valid, output a_re, output a_im, output b_re, output b_im);

  // consumer side
  modport dst (input valid, input a_re, input a_im, input b_re, input b_im);

endinterface

/* design/sample_stage.sv */
`timescale 1ns/10ps

module sample_stage
  import fft_fmt_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    in_valid,
  input  logic    scale,
  input  sample_t a_re,
  input  sample_t a_im,
  input  sample_t b_re,
  input  sample_t b_im,
  sample_if.src   smp
);

  // optional halving for block scaling
  // arithmetic shift, so odd negatives floor toward -inf
  function automatic sample_t halve(input sample_t s, input logic en);
    sample_t r;
    if (en) begin
      r = s >>> 1;
    end else begin
      r = s;
    end
    return r;
  endfunction

  // strobe register
  always_ff @(posedge clk) begin
    if (reset) begin
      smp.valid <= 1'b0;
    end else begin
      smp.valid <= in_valid;
    end
  end

  // operand registers
  // only capture on a strobe, otherwise hold
  always_ff @(posedge clk) begin
    if (in_valid) begin
      smp.a_re <= halve(a_re, scale);
      smp.a_im <= halve(a_im, scale);
      smp.b_re <= halve(b_re, scale);
      smp.b_im <= halve(b_im, scale);
    end
  end

endmodule

/* design/twiddle_lookup.sv */
`timescale 1ns/10ps

module twiddle_lookup
  import fft_fmt_pkg::*;
  import fft_op_pkg::*;
(
  input  logic           clk,
  input  logic [k_w-1:0] k,
  input  bfly_op_e       op,
  output twiddle_t       w_re,
  output twiddle_t       w_im
);

  twiddle_t sine [fft_n];
  logic [k_w-1:0] k_cos;
  twiddle_t sin_k;
  twiddle_t cos_k;

  // constant table, no clock or state inside
  fft_sine_wave #(
    .N(fft_n),
    .D(tw_frac)
  ) i_fft_sine_wave (
    .out(sine)
  );

  // cos(x) = sin(x + pi/2), a quarter turn further on
  // the k_w-bit sum wraps mod fft_n by itself
  assign k_cos = k + k_w'(fft_n / 4);

  assign sin_k = sine[k];
  assign cos_k = sine[k_cos];

  // loads every cycle
  // the core only looks at it alongside a valid sample pair
  always_ff @(posedge clk) begin
    w_re <= cos_k;
    // forward twiddle has -sin on the imaginary part
    if (op == op_inv) begin
      w_im <= sin_k;
    end else begin
      w_im <= -sin_k;
    end
  end

endmodule

/* fft_butterfly.f */
design/fft_fmt_pkg.sv
design/fft_op_pkg.sv
design/fft_sine_wave.sv
design/twiddle_lookup.sv
design/sample_if.sv
design/sample_stage.sv
design/butterfly_core.sv
design/fft_butterfly_top.sv
bench/fft_butterfly_chk.sv
bench/fft_butterfly_tb.sv
